/* Bender.yml */
package:
  name: timing_beacon

sources:
  - common/beacon_pkg.sv
  - common/beat_if.sv
  - beat/beat_sequencer.sv
  - beat/xgmii_beat_port.sv
  - verilog/pps_generator.sv
  - verilog/timing_beacon.sv
  - target: test
    files:
      - bench/beacon_checker.sv
      - bench/tb_timing_beacon.sv

/* beat/beat_sequencer.sv */
// Beat frame sequencer

`timescale 1ns/1ns

module beat_sequencer (
  input  logic     TEN_MHZ_INA,
  input  logic     rst_n,
  input  logic     pps_in,
  beat_if.sequencer beat
);

  // Two-flop synchronizer for the external PPS
  logic pps_meta;
  logic pps_sync;

  beacon_pkg::beat_step_t step_q;

  //--------------------------------------------------------------------------
  // PPS synchronizer
  //--------------------------------------------------------------------------
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      pps_meta <= 1'b0;
      pps_sync <= 1'b0;
    end else begin
      pps_meta <= pps_in;
      pps_sync <= pps_meta;
    end
  end

  //--------------------------------------------------------------------------
  // Step counter
  //--------------------------------------------------------------------------

  // Leaves idle on the PPS level, so a long pulse starts back-to-back frames
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      step_q <= beacon_pkg::STEP_IDLE;
    end else begin
      case (step_q)
        beacon_pkg::STEP_IDLE: begin
          if (pps_sync) begin
            step_q <= beacon_pkg::STEP_START;
          end
        end
        beacon_pkg::STEP_TERM: begin
          step_q <= beacon_pkg::STEP_IDLE;
        end
        default: begin
          step_q <= step_q + 4'd1;
        end
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Word selection decode
  //--------------------------------------------------------------------------
  assign beat.step         = step_q;
  assign beat.send_idle    = (step_q == beacon_pkg::STEP_IDLE);
  assign beat.send_start   = (step_q == beacon_pkg::STEP_START);
  assign beat.send_payload = (step_q >= beacon_pkg::FIRST_PAYLOAD) &&
                             (step_q <= beacon_pkg::LAST_PAYLOAD);
  assign beat.send_term    = (step_q == beacon_pkg::STEP_TERM);

endmodule

/* beat/xgmii_beat_port.sv */
// XGMII beat transmit and receive port

`timescale 1ns/1ns

module xgmii_beat_port (
  input  logic                    TEN_MHZ_INA,
  input  logic                    rst_n,
  beat_if.port                    beat,
  input  beacon_pkg::xgmii_ctrl_t xgmii_rxc,
  output beacon_pkg::xgmii_word_u xgmii_txd,
  output beacon_pkg::xgmii_ctrl_t xgmii_txc,
  output logic                    beat_send,
  output logic                    beat_recv
);

  beacon_pkg::xgmii_word_u next_txd;
  beacon_pkg::xgmii_ctrl_t next_txc;

  //--------------------------------------------------------------------------
  // Word builder
  //--------------------------------------------------------------------------
  always_comb begin
    next_txd.word = '0;
    next_txc      = beacon_pkg::CTRL_ALL;
    unique case (1'b1)
      beat.send_start: begin
        // Start character, preamble and SFD
        next_txd.lane[0] = beacon_pkg::XGMII_START;
        for (int i = 1; i < 7; i++) begin
          next_txd.lane[i] = beacon_pkg::PREAMBLE_BYTE;
        end
        next_txd.lane[7] = beacon_pkg::SFD_BYTE;
        next_txc         = beacon_pkg::CTRL_START;
      end
      beat.send_payload: begin
        // Sequence number as one plain data word
        next_txd.word = 64'(beat.step);
        next_txc      = beacon_pkg::CTRL_NONE;
      end
      beat.send_term: begin
        next_txd.lane[0] = beacon_pkg::XGMII_TERM;
        for (int i = 1; i < 8; i++) begin
          next_txd.lane[i] = beacon_pkg::XGMII_IDLE;
        end
      end
      beat.send_idle: begin
        for (int i = 0; i < 8; i++) begin
          next_txd.lane[i] = beacon_pkg::XGMII_IDLE;
        end
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // Output registers
  //--------------------------------------------------------------------------
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      xgmii_txd.word <= {8{beacon_pkg::XGMII_IDLE}};
      xgmii_txc      <= beacon_pkg::CTRL_ALL;
      beat_send      <= 1'b0;
    end else begin
      xgmii_txd <= next_txd;
      xgmii_txc <= next_txc;
      beat_send <= !beat.send_idle;
    end
  end

  // Anything other than all-control on the receive lanes counts as activity
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      beat_recv <= 1'b0;
    end else begin
      beat_recv <= (xgmii_rxc != beacon_pkg::CTRL_ALL);
    end
  end

endmodule

/* bench/beacon_checker.sv */
// Beacon output checker

`timescale 1ns/1ns

module beacon_checker #(
  parameter int unsigned PULSE_TICKS = 100
) (
  input  logic        TEN_MHZ_INA,
  input  logic        rst_n,

  // DUT outputs
  input  logic        pps_out,
  input  logic [63:0] xgmii_txd,
  input  logic [7:0]  xgmii_txc,
  input  logic        beat_send,
  input  logic        beat_recv,

  // Expected values from the reference functions
  input  logic [63:0] exp_txd,
  input  logic [7:0]  exp_txc,
  input  logic        exp_send,
  input  logic        exp_recv,
  input  int          exp_interval,

  output int          error_count,
  output int          check_count,
  output int          interval_count
);

  // High when the last rising edge ran out of reset
  logic run_q;

  logic pps_prev;
  logic rise_seen;
  int   since_rise;
  int   high_len;

  initial begin
    run_q          = 1'b0;
    pps_prev       = 1'b0;
    rise_seen      = 1'b0;
    since_rise     = 0;
    high_len       = 0;
    error_count    = 0;
    check_count    = 0;
    interval_count = 0;
  end

  always @(posedge TEN_MHZ_INA) begin
    run_q <= rst_n;
  end

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  //--------------------------------------------------------------------------
  // PPS period and pulse width
  //--------------------------------------------------------------------------
  task automatic check_pps();
    since_rise++;
    if (pps_out && !pps_prev) begin
      if (rise_seen) begin
        interval_count++;
        compare("pps_out interval", 64'(since_rise), 64'(exp_interval));
      end
      rise_seen  = 1'b1;
      since_rise = 0;
    end
    if (pps_out) begin
      high_len++;
    end else if (pps_prev) begin
      compare("pps_out high time", 64'(high_len), 64'(PULSE_TICKS));
      high_len = 0;
    end
    pps_prev = pps_out;
  endtask

  // Registered outputs are settled by the falling edge
  always @(negedge TEN_MHZ_INA) begin
    if (run_q) begin
      compare("xgmii_txd", xgmii_txd, exp_txd);
      compare("xgmii_txc", 64'(xgmii_txc), 64'(exp_txc));
      compare("beat_send", 64'(beat_send), 64'(exp_send));
      compare("beat_recv", 64'(beat_recv), 64'(exp_recv));
      check_pps();
    end
  end

endmodule

/* bench/tb_timing_beacon.sv */
// Timing beacon testbench

`timescale 1ns/1ns

module tb_timing_beacon;

  localparam int unsigned SECOND_TICKS = 1000;
  localparam int unsigned PULSE_TICKS  = 10;
  localparam int TIMEOUT_CYCLES = 6 * SECOND_TICKS + 2000;
  localparam int PULSE_COUNT    = 8;
  localparam int MIN_INTERVALS  = 5;
  // Nine frame words and the idle step before the next start
  localparam int FRAME_PERIOD   = 10;
  localparam logic [15:0] LFSR_SEED = 16'd47343;

  logic        TEN_MHZ_INA = 1'b0;
  logic        rst_n;
  logic        pps_in;
  logic [32:0] adjust_value;
  logic        adjust_flag;
  logic [7:0]  xgmii_rxc;
  logic        pps_out;
  logic [63:0] xgmii_txd;
  logic [7:0]  xgmii_txc;
  logic        beat_send;
  logic        beat_recv;

  logic [15:0] lfsr_state;
  int          draw_value;
  int          rxc_coin;
  int          rxc_bits;
  int          pulse_len [PULSE_COUNT];
  int          pulse_gap [PULSE_COUNT];
  int          adjust_a;

  // Expected outputs for the current cycle
  int          cycle_count;
  int          frame_base;
  int          frame_words;
  int          frame_pos;
  logic [63:0] exp_txd;
  logic [7:0]  exp_txc;
  logic        exp_send;
  logic        exp_recv;
  int          exp_interval;

  int          checker_errors;
  int          check_count;
  int          interval_count;
  int          tb_errors;

  timing_beacon #(
    .SECOND_TICKS (SECOND_TICKS),
    .PULSE_TICKS  (PULSE_TICKS)
  ) timing_beacon_i (
    .TEN_MHZ_INA  (TEN_MHZ_INA),
    .rst_n        (rst_n),
    .pps_in       (pps_in),
    .adjust_value (adjust_value),
    .adjust_flag  (adjust_flag),
    .xgmii_rxc    (xgmii_rxc),
    .pps_out      (pps_out),
    .xgmii_txd    (xgmii_txd),
    .xgmii_txc    (xgmii_txc),
    .beat_send    (beat_send),
    .beat_recv    (beat_recv)
  );

  beacon_checker #(
    .PULSE_TICKS (PULSE_TICKS)
  ) beacon_checker_i (
    .TEN_MHZ_INA    (TEN_MHZ_INA),
    .rst_n          (rst_n),
    .pps_out        (pps_out),
    .xgmii_txd      (xgmii_txd),
    .xgmii_txc      (xgmii_txc),
    .beat_send      (beat_send),
    .beat_recv      (beat_recv),
    .exp_txd        (exp_txd),
    .exp_txc        (exp_txc),
    .exp_send       (exp_send),
    .exp_recv       (exp_recv),
    .exp_interval   (exp_interval),
    .error_count    (checker_errors),
    .check_count    (check_count),
    .interval_count (interval_count)
  );

  always #50 TEN_MHZ_INA = ~TEN_MHZ_INA;

  //--------------------------------------------------------------------------
  // Reference functions
  //--------------------------------------------------------------------------

  // Word position 0 is start, 1 to 7 payload, 8 terminate, -1 idle
  function automatic logic [63:0] expected_word(input int pos);
    if (pos == 0) begin
      return {beacon_pkg::SFD_BYTE, {6{beacon_pkg::PREAMBLE_BYTE}}, beacon_pkg::XGMII_START};
    end else if (pos >= 1 && pos <= 7) begin
      return 64'(pos + 1);
    end else if (pos == 8) begin
      return {{7{beacon_pkg::XGMII_IDLE}}, beacon_pkg::XGMII_TERM};
    end
    return {8{beacon_pkg::XGMII_IDLE}};
  endfunction

  function automatic logic [7:0] expected_ctrl(input int pos);
    if (pos == 0) begin
      return beacon_pkg::CTRL_START;
    end else if (pos >= 1 && pos <= 7) begin
      return beacon_pkg::CTRL_NONE;
    end
    return beacon_pkg::CTRL_ALL;
  endfunction

  // A new frame starts every period while the pulse is still sampled high
  function automatic int expected_frames(input int len);
    return (len - 1) / FRAME_PERIOD + 1;
  endfunction

  function automatic int word_position(input int cycle, input int base, input int words);
    int offset;
    offset = cycle - base;
    if (offset < 0 || offset >= words || offset % FRAME_PERIOD == FRAME_PERIOD - 1) begin
      return -1;
    end
    return offset % FRAME_PERIOD;
  endfunction

  function automatic int expected_interval(input logic adjusted, input int a);
    return adjusted ? 2 * SECOND_TICKS - a : SECOND_TICKS;
  endfunction

  function automatic logic expected_recv(input logic [7:0] rxc);
    return rxc != 8'hff;
  endfunction

  always_comb begin
    frame_pos = word_position(cycle_count, frame_base, frame_words);
    exp_txd   = expected_word(frame_pos);
    exp_txc   = expected_ctrl(frame_pos);
    exp_send  = (frame_pos >= 0);
  end

  always @(posedge TEN_MHZ_INA) begin
    exp_recv <= expected_recv(xgmii_rxc);
  end

  //--------------------------------------------------------------------------
  // Random numbers
  //--------------------------------------------------------------------------
  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  // Receive lanes, all-control about half the time
  always @(negedge TEN_MHZ_INA) begin
    draw_bits(1, rxc_coin);
    if (rxc_coin == 1) begin
      xgmii_rxc = 8'hff;
    end else begin
      draw_bits(8, rxc_bits);
      xgmii_rxc = 8'(rxc_bits);
    end
  end

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------
  task automatic send_pps_pulses();
    for (int i = 0; i < PULSE_COUNT; i++) begin
      // Sampled on the next edge, start word three edges after that
      frame_base  = cycle_count + 4;
      frame_words = FRAME_PERIOD * expected_frames(pulse_len[i]);
      pps_in = 1'b1;
      repeat (pulse_len[i]) @(negedge TEN_MHZ_INA);
      pps_in = 1'b0;
      repeat (pulse_gap[i]) @(negedge TEN_MHZ_INA);
    end
  endtask

  // Returns clear of the negedge where the checker sees the rise
  task automatic wait_pps_rise();
    @(posedge pps_out);
    repeat (2) @(negedge TEN_MHZ_INA);
  endtask

  task automatic adjust_phase();
    repeat (2) wait_pps_rise();
    adjust_value = 33'(adjust_a);
    adjust_flag  = ~adjust_flag;
    exp_interval = expected_interval(1'b1, adjust_a);
    wait_pps_rise();
    exp_interval = expected_interval(1'b0, adjust_a);
    repeat (2) wait_pps_rise();
  endtask

  task automatic report_results();
    if (interval_count < MIN_INTERVALS) begin
      $display("Too few PPS intervals were checked: %0d", interval_count);
      tb_errors++;
    end
    $display("Checks: %0d, PPS intervals: %0d, errors: %0d", check_count, interval_count,
             checker_errors + tb_errors);
    if (checker_errors + tb_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  always @(posedge TEN_MHZ_INA) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    rst_n        = 1'b0;
    pps_in       = 1'b0;
    adjust_value = '0;
    adjust_flag  = 1'b0;
    xgmii_rxc    = 8'hff;
    cycle_count  = 0;
    frame_base   = 0;
    frame_words  = 0;
    exp_recv     = 1'b0;
    exp_interval = expected_interval(1'b0, 0);
    tb_errors    = 0;
    lfsr_state   = LFSR_SEED;
    for (int i = 0; i < PULSE_COUNT; i++) begin
      draw_bits(5, draw_value);
      pulse_len[i] = draw_value + 1;
      draw_bits(5, draw_value);
      pulse_gap[i] = draw_value + 24;
    end
    draw_bits(10, draw_value);
    adjust_a = PULSE_TICKS + draw_value % (SECOND_TICKS - PULSE_TICKS);
    repeat (16) @(posedge TEN_MHZ_INA);
    @(negedge TEN_MHZ_INA);
    rst_n = 1'b1;
    // Reset state holds while pps_in stays low
    repeat (20) @(negedge TEN_MHZ_INA);
    fork
      send_pps_pulses();
      adjust_phase();
    join
    repeat (5) @(negedge TEN_MHZ_INA);
    report_results();
  end

endmodule

/* common/beacon_pkg.sv */
// Timing beacon shared definitions

package beacon_pkg;

  //--------------------------------------------------------------------------
  // XGMII word types
  //--------------------------------------------------------------------------

  // One transmit or receive data word, seen whole or as byte lanes
  // Lane 0 is the least significant byte
  typedef union packed {
    logic [63:0]     word;
    logic [7:0][7:0] lane;
  } xgmii_word_u;

  // One control bit per lane, set for a control character
  typedef logic [7:0] xgmii_ctrl_t;

  //--------------------------------------------------------------------------
  // XGMII characters and control vectors
  //--------------------------------------------------------------------------

  localparam logic [7:0] XGMII_IDLE    = 8'h07;
  localparam logic [7:0] XGMII_START   = 8'hfb;
  localparam logic [7:0] XGMII_TERM    = 8'hfd;
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hd5;

  localparam xgmii_ctrl_t CTRL_ALL   = 8'hff;
  localparam xgmii_ctrl_t CTRL_START = 8'h01;
  localparam xgmii_ctrl_t CTRL_NONE  = 8'h00;

  //--------------------------------------------------------------------------
  // Beat frame layout
  //--------------------------------------------------------------------------

  // Step 0 idle, 1 start, 2 to 8 payload, 9 terminate
  typedef logic [3:0] beat_step_t;

  localparam beat_step_t STEP_IDLE     = 4'd0;
  localparam beat_step_t STEP_START    = 4'd1;
  localparam beat_step_t FIRST_PAYLOAD = 4'd2;
  localparam beat_step_t LAST_PAYLOAD  = 4'd8;
  localparam beat_step_t STEP_TERM     = 4'd9;

  //--------------------------------------------------------------------------
  // PPS generator
  //--------------------------------------------------------------------------

  // Reference cycles counted within one second
  typedef logic [32:0] pps_count_t;

endpackage

/* common/beat_if.sv */
// Beat frame word selection

`timescale 1ns/1ns

interface beat_if;

  // One-hot word selection, exactly one line high each cycle
  logic send_idle;
  logic send_start;
  logic send_payload;
  logic send_term;

  // Current frame step, used as the payload sequence number
  beacon_pkg::beat_step_t step;

  modport sequencer (
    output send_idle,
    output send_start,
    output send_payload,
    output send_term,
    output step
  );

  modport port (
    input send_idle,
    input send_start,
    input send_payload,
    input send_term,
    input step
  );

endinterface

/* project.f */
common/beacon_pkg.sv
common/beat_if.sv
beat/beat_sequencer.sv
beat/xgmii_beat_port.sv
verilog/pps_generator.sv
verilog/timing_beacon.sv
bench/beacon_checker.sv
bench/tb_timing_beacon.sv

/* verilog/pps_generator.sv */
// Internal one pulse per second generator

`timescale 1ns/1ns

module pps_generator #(
  parameter int unsigned SECOND_TICKS = 10_000_000,
  parameter int unsigned PULSE_TICKS  = 100
) (
  input  logic                   TEN_MHZ_INA,
  input  logic                   rst_n,
  input  beacon_pkg::pps_count_t adjust_value,
  input  logic                   adjust_flag,
  output logic                   pps_out
);

  localparam beacon_pkg::pps_count_t LAST_COUNT  = beacon_pkg::pps_count_t'(SECOND_TICKS - 1);
  localparam beacon_pkg::pps_count_t PULSE_COUNT = beacon_pkg::pps_count_t'(PULSE_TICKS);

  beacon_pkg::pps_count_t second_cnt;

  // Last adjust flag taken, a change requests a new phase
  logic flag_seen;

  //--------------------------------------------------------------------------
  // Second counter with phase adjustment
  //--------------------------------------------------------------------------
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      second_cnt <= '0;
      flag_seen  <= 1'b0;
    end else if (second_cnt < LAST_COUNT) begin
      second_cnt <= second_cnt + 1'b1;
    end else if (adjust_flag != flag_seen) begin
      // New phase only at the second boundary
      second_cnt <= adjust_value;
      flag_seen  <= adjust_flag;
    end else begin
      second_cnt <= '0;
    end
  end

  //--------------------------------------------------------------------------
  // Pulse register
  //--------------------------------------------------------------------------
  always_ff @(posedge TEN_MHZ_INA) begin
    if (!rst_n) begin
      pps_out <= 1'b0;
    end else begin
      pps_out <= (second_cnt < PULSE_COUNT);
    end
  end

endmodule

/* verilog/timing_beacon.sv */
// Timing beacon top level

`timescale 1ns/1ns

module timing_beacon #(
  parameter int unsigned SECOND_TICKS = 10_000_000,
  parameter int unsigned PULSE_TICKS  = 100
) (
  input  logic        TEN_MHZ_INA,
  input  logic        rst_n,

  // External PPS that triggers the beat frame
  input  logic        pps_in,

  // Phase adjustment for the internal PPS
  input  logic [32:0] adjust_value,
  input  logic        adjust_flag,

  input  logic [7:0]  xgmii_rxc,

  output logic        pps_out,
  output logic [63:0] xgmii_txd,
  output logic [7:0]  xgmii_txc,
  output logic        beat_send,
  output logic        beat_recv
);

  beat_if beat_bus ();

  //--------------------------------------------------------------------------
  // Internal PPS
  //--------------------------------------------------------------------------
  pps_generator #(
    .SECOND_TICKS (SECOND_TICKS),
    .PULSE_TICKS  (PULSE_TICKS)
  ) pps_generator_i (
    .TEN_MHZ_INA  (TEN_MHZ_INA),
    .rst_n        (rst_n),
    .adjust_value (adjust_value),
    .adjust_flag  (adjust_flag),
    .pps_out      (pps_out)
  );

  //--------------------------------------------------------------------------
  // Beat frame
  //--------------------------------------------------------------------------
  beat_sequencer beat_sequencer_i (
    .TEN_MHZ_INA (TEN_MHZ_INA),
    .rst_n       (rst_n),
    .pps_in      (pps_in),
    .beat        (beat_bus.sequencer)
  );

  xgmii_beat_port xgmii_beat_port_i (
    .TEN_MHZ_INA (TEN_MHZ_INA),
    .rst_n       (rst_n),
    .beat        (beat_bus.port),
    .xgmii_rxc   (xgmii_rxc),
    .xgmii_txd   (xgmii_txd),
    .xgmii_txc   (xgmii_txc),
    .beat_send   (beat_send),
    .beat_recv   (beat_recv)
  );

endmodule
